// File: Bender.yml
package:
  name: ptp_tag

export_include_dirs:
  - .

sources:
  - files:
      - ptp_tag_pkg.sv
      - ptp_tag_alloc.sv
      - ptp_tag_insert.sv
      - ptp_frame_arbiter.sv
      - ptp_tag_subsys.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_ptp_checker.sv
      - tb_ptp_tag_sva.sv
      - tb_ptp_tag.sv

// File: flist.f
+incdir+.
ptp_tag_pkg.sv
ptp_tag_alloc.sv
ptp_tag_insert.sv
ptp_frame_arbiter.sv
ptp_tag_subsys.sv
tb_clk_gen.sv
tb_ptp_checker.sv
tb_ptp_tag_sva.sv
tb_ptp_tag.sv

// File: ptp_frame_arbiter.sv
// Round-robin merge at frame boundaries only; one registered output stage, no skid buffer.
`include "ptp_tag_macros.svh"

module ptp_frame_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  ptp_tag_pkg::axis_beat_t   ins_beat  [`PTP_NUM_LANES],
    input  logic [`PTP_NUM_LANES-1:0] ins_valid,
    output logic [`PTP_NUM_LANES-1:0] ins_ready,
    output ptp_tag_pkg::axis_beat_t   out_beat,
    output logic                      out_valid,
    input  logic                      out_ready
);

    // ==================================================================
    // State
    // ==================================================================

    ptp_tag_pkg::arb_state_t state_q;            // Idle or locked on one lane.
    ptp_tag_pkg::lane_t      ptr_q;              // First lane looked at when idle.
    ptp_tag_pkg::lane_t      lock_q;             // Lane that owns the output mid-frame.

    logic               found;                   // Some lane is pending in idle.
    ptp_tag_pkg::lane_t pick;                    // Round-robin choice in idle.
    ptp_tag_pkg::lane_t sel_lane;                // Lane connected to the output this cycle.
    logic               grant;                   // A lane is connected at all.
    logic               sel_valid;               // The connected lane offers a beat.
    logic               load_en;                 // Output register can take a beat.
    logic               xfer;                    // A beat moves into the register.

    // ==================================================================
    // Round-robin search
    // ==================================================================

    always_comb begin
        int idx;                                 // Lane under test, wrapped.
        found = 1'b0;
        pick  = ptr_q;
        for (int i = 0; i < `PTP_NUM_LANES; i++) begin
            idx = (int'(ptr_q) + i) % `PTP_NUM_LANES; // Scan from the pointer upward.
            if (!found && ins_valid[idx]) begin
                found = 1'b1;                    // First hit wins, later ones are ignored.
                pick  = ptp_tag_pkg::lane_t'(idx);
            end
        end
    end

    // ==================================================================
    // Grant and handshakes
    // ==================================================================

    assign grant     = (state_q == ptp_tag_pkg::ARB_LOCKED) || found; // Same-cycle grant.
    assign sel_lane  = (state_q == ptp_tag_pkg::ARB_LOCKED) ? lock_q : pick;
    assign sel_valid = grant && ins_valid[sel_lane]; // Beat offered by the granted lane.
    assign load_en   = !out_valid || out_ready;  // Empty or draining this cycle.
    assign xfer      = sel_valid && load_en;     // Input handshake of the granted lane.

    always_comb begin
        for (int k = 0; k < `PTP_NUM_LANES; k++) begin
            // Only the granted lane sees ready, so frames never interleave.
            ins_ready[k] = grant && load_en && (sel_lane == ptp_tag_pkg::lane_t'(k));
        end
    end

    // ==================================================================
    // Frame lock FSM
    // ==================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ptp_tag_pkg::ARB_IDLE;    // Start unlocked.
            ptr_q   <= '0;                       // Lane 0 has first pick.
            lock_q  <= '0;
        end else if (xfer) begin
            if (ins_beat[sel_lane].last) begin
                state_q <= ptp_tag_pkg::ARB_IDLE; // Frame done, open the output again.
                // Next search starts just past the lane that finished.
                ptr_q <= ptp_tag_pkg::lane_t'((int'(sel_lane) + 1) % `PTP_NUM_LANES);
            end else begin
                state_q <= ptp_tag_pkg::ARB_LOCKED; // Hold the lane for the rest of the frame.
                lock_q  <= sel_lane;
            end
        end
    end

    // ==================================================================
    // Output register
    // ==================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;                   // Output empty after reset.
        end else if (load_en) begin
            out_valid <= sel_valid;              // Refill or go empty.
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            out_beat <= ins_beat[sel_lane];      // Holds still while stalled.
        end
    end

endmodule

// File: ptp_tag_alloc.sv
// Offers one tag per lane at a time; sequence counts wrap modulo 2**14 and restart at 0 on reset.
`include "ptp_tag_macros.svh"

module ptp_tag_alloc (
    input  logic                clk,
    input  logic                rst,
    output ptp_tag_pkg::tag_t   tag       [`PTP_NUM_LANES],
    output logic [`PTP_NUM_LANES-1:0] tag_valid,
    input  logic [`PTP_NUM_LANES-1:0] tag_ready
);

    // ==================================================================
    // Per-lane state
    // ==================================================================

    ptp_tag_pkg::seq_t seq_q [`PTP_NUM_LANES];  // Frame count of each lane.
    logic [`PTP_NUM_LANES-1:0] valid_q;          // Registered offer flag per lane.

    // ==================================================================
    // One counter and offer flag per lane
    // ==================================================================

    for (genvar k = 0; k < `PTP_NUM_LANES; k++) begin : g_lane

        logic take;                              // A tag moves to the insert block.

        assign take = valid_q[k] && tag_ready[k]; // Handshake of this lane's tag.

        // The lane number comes from the loop index, so no two lanes
        // can ever produce the same tag value.
        assign tag[k] = {ptp_tag_pkg::lane_t'(k), seq_q[k]};

        assign tag_valid[k] = valid_q[k];        // Offer straight from the flop.

        always_ff @(posedge clk) begin
            if (rst) begin
                seq_q[k]   <= '0;                // First frame of the lane gets count 0.
                valid_q[k] <= 1'b0;              // Nothing is offered during reset.
            end else begin
                valid_q[k] <= 1'b1;              // Offer rises the first cycle after reset.
                if (take) begin
                    seq_q[k] <= seq_q[k] + 1'b1; // Next tag shows one cycle later.
                end
            end
        end

    end

    // The offer flag stays high once raised because the insert block drops
    // its ready while it holds a tag. The tag value on the port therefore
    // only changes at a transfer edge, which keeps it stable while offered.

endmodule

// File: ptp_tag_insert.sv
// Holds one tag per frame; the frame waits until a tag is held and the arbiter grants this lane.
`include "ptp_tag_macros.svh"

module ptp_tag_insert (
    input  logic                    clk,
    input  logic                    rst,
    input  ptp_tag_pkg::axis_beat_t in_beat,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  ptp_tag_pkg::tag_t       tag,
    input  logic                    tag_valid,
    output logic                    tag_ready,
    output ptp_tag_pkg::axis_beat_t ins_beat,
    output logic                    ins_valid,
    input  logic                    ins_ready
);

    ptp_tag_pkg::tag_t tag_q;                    // Tag of the frame now passing.
    logic              held_q;                   // High while a tag is owned.
    logic              last_xfer;                // Final beat of the frame is accepted.

    // ==================================================================
    // Stream path
    // ==================================================================

    assign in_ready  = ins_ready && held_q;      // No beat moves before the tag is held.
    assign ins_valid = in_valid && held_q;       // Hide the beat from the arbiter until tagged.
    assign tag_ready = !held_q;                  // Ask for a tag only when none is owned.

    assign last_xfer = in_valid && in_ready && in_beat.last; // Frame closes on this edge.

    always_comb begin
        ins_beat = in_beat;                      // Data, keep, last and bit 0 pass through.
        ins_beat.user[`PTP_TAG_OFFSET +: `PTP_TAG_WIDTH] = tag_q; // Tag overwrites bits 16:1.
    end

    // ==================================================================
    // Tag ownership
    // ==================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            held_q <= 1'b0;                      // Start with no tag owned.
        end else if (held_q) begin
            if (last_xfer) begin
                held_q <= 1'b0;                  // Release after the last beat leaves.
            end
        end else if (tag_valid) begin
            held_q <= 1'b1;                      // Tag taken while ready was high.
        end
    end

    always_ff @(posedge clk) begin
        if (!held_q && tag_valid) begin
            tag_q <= tag;                        // Capture on the tag handshake only.
        end
    end

endmodule

// File: ptp_tag_macros.svh
// Widths and lane count are fixed at compile time; PTP_NUM_LANES must equal 2**PTP_LANE_BITS.
`ifndef PTP_TAG_MACROS_SVH
`define PTP_TAG_MACROS_SVH

// ======================================================================
// Stream beat geometry
// ======================================================================

`define PTP_DATA_WIDTH 64                        // Data bits carried per beat.
`define PTP_KEEP_WIDTH 8                         // One keep bit per data byte.

// ======================================================================
// Tag layout
// ======================================================================

`define PTP_TAG_WIDTH  16                        // Full tag width, lane plus sequence.
`define PTP_TAG_OFFSET 1                         // Tag starts above the pass-through bit.
`define PTP_USER_WIDTH 17                        // Pass-through bit plus the tag field.

// ======================================================================
// Lane configuration
// ======================================================================

`define PTP_NUM_LANES  4                         // Number of frame sources merged.
`define PTP_LANE_BITS  2                         // Lane number width in the tag MSBs.

`endif

// File: ptp_tag_pkg.sv
// Types for the tag subsystem; the tag always carries the lane number in its top PTP_LANE_BITS.
`include "ptp_tag_macros.svh"

package ptp_tag_pkg;

    // ==================================================================
    // Plain vector types with a meaning
    // ==================================================================

    typedef logic [`PTP_DATA_WIDTH-1:0] data_t;  // One beat of frame payload.
    typedef logic [`PTP_KEEP_WIDTH-1:0] keep_t;  // Byte enables of one beat.
    typedef logic [`PTP_USER_WIDTH-1:0] user_t;  // Bit 0 passes through, the rest is the tag.
    typedef logic [`PTP_TAG_WIDTH-1:0]  tag_t;   // Lane number over sequence count.
    typedef logic [`PTP_LANE_BITS-1:0]  lane_t;  // Index of a source lane.

    // Per-lane frame counter fills the tag bits below the lane number.
    typedef logic [`PTP_TAG_WIDTH-`PTP_LANE_BITS-1:0] seq_t;

    // ==================================================================
    // Stream beat
    // ==================================================================

    typedef struct packed {
        data_t data;                             // Payload bytes.
        keep_t keep;                             // Valid byte mask.
        logic  last;                             // Marks the final beat of a frame.
        user_t user;                             // Sideband with the tag field.
    } axis_beat_t;

    // ==================================================================
    // Arbiter states
    // ==================================================================

    typedef enum logic [0:0] {
        ARB_IDLE   = 1'b0,                       // Free to grant any pending lane.
        ARB_LOCKED = 1'b1                        // Bound to one lane until its last beat.
    } arb_state_t;

endpackage

// File: ptp_tag_subsys.sv
// Top of the tag subsystem; sources must keep a beat stable until in_ready takes it.
`include "ptp_tag_macros.svh"

module ptp_tag_subsys (
    input  logic                      clk,
    input  logic                      rst,
    input  ptp_tag_pkg::axis_beat_t   in_beat   [`PTP_NUM_LANES],
    input  logic [`PTP_NUM_LANES-1:0] in_valid,
    output logic [`PTP_NUM_LANES-1:0] in_ready,
    output ptp_tag_pkg::axis_beat_t   out_beat,
    output logic                      out_valid,
    input  logic                      out_ready
);

    // ==================================================================
    // Internal links
    // ==================================================================

    ptp_tag_pkg::tag_t         tag       [`PTP_NUM_LANES]; // Offered tag per lane.
    logic [`PTP_NUM_LANES-1:0] tag_valid;                  // Allocator offers a tag.
    logic [`PTP_NUM_LANES-1:0] tag_ready;                  // Insert block wants a tag.

    ptp_tag_pkg::axis_beat_t   ins_beat  [`PTP_NUM_LANES]; // Tagged beat per lane.
    logic [`PTP_NUM_LANES-1:0] ins_valid;                  // Tagged beat is offered.
    logic [`PTP_NUM_LANES-1:0] ins_ready;                  // Arbiter accepts the lane.

    // ==================================================================
    // Tag allocator
    // ==================================================================

    ptp_tag_alloc u_alloc (
        .clk       (clk),
        .rst       (rst),
        .tag       (tag),
        .tag_valid (tag_valid),
        .tag_ready (tag_ready)
    );

    // ==================================================================
    // One insert block per lane
    // ==================================================================

    for (genvar g = 0; g < `PTP_NUM_LANES; g++) begin : g_insert
        ptp_tag_insert u_insert (
            .clk       (clk),
            .rst       (rst),
            .in_beat   (in_beat[g]),
            .in_valid  (in_valid[g]),
            .in_ready  (in_ready[g]),
            .tag       (tag[g]),
            .tag_valid (tag_valid[g]),
            .tag_ready (tag_ready[g]),
            .ins_beat  (ins_beat[g]),
            .ins_valid (ins_valid[g]),
            .ins_ready (ins_ready[g])
        );
    end

    // ==================================================================
    // Frame arbiter
    // ==================================================================

    ptp_frame_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .ins_beat  (ins_beat),
        .ins_valid (ins_valid),
        .ins_ready (ins_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// File: ptp_tag_trace.txt
# lane data(hex, 64 bit) keep(hex) last user0
# Beats of one lane go out in file order; a frame ends on last=1.
0 0001020304050607 ff 0 1
0 08090a0b0c0d0e0f 0f 1 1
1 1111111111111111 ff 0 0
1 2222222222222222 ff 0 1
1 3333333333333333 3f 1 0
2 a5a5a5a5a5a5a5a5 01 1 1
3 0123456789abcdef ff 0 0
3 fedcba9876543210 ff 0 0
3 0badc0de12345678 ff 0 1
3 00000000000000ff 03 1 0
0 1020304050607080 ff 1 0
2 5a5a5a5a5a5a5a5a ff 0 0
2 0f0f0f0f0f0f0f0f 7f 1 1
0 9988776655443322 ff 0 1
0 aabbccddeeff0011 ff 0 0
0 1122334455667788 1f 1 1
1 4444444444444444 ff 0 1
1 5555555555555555 ff 1 0

// File: tb_clk_gen.sv
// Free-running clock of period 20 from time 0; reset stays high for the first 3 rising edges.
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;                              // First rising edge at time 10.
        forever #10 clk = ~clk;                  // Half period of 10 gives a period of 20.
    end

    initial begin
        rst = 1'b1;                              // Reset is active from the very start.
        repeat (3) @(posedge clk);
        rst <= 1'b0;                             // Released after 3 sampled edges.
    end

endmodule

// File: tb_ptp_checker.sv
// Expects lane-ordered trace beats via add_beat; holds at most 256 beats in total.
`include "ptp_tag_macros.svh"

module tb_ptp_checker (
    input logic                      clk,
    input logic                      rst,
    input logic [`PTP_NUM_LANES-1:0] in_valid,
    input logic [`PTP_NUM_LANES-1:0] in_ready,
    input ptp_tag_pkg::axis_beat_t   out_beat,
    input logic                      out_valid,
    input logic                      out_ready,
    input int                        assert_errors
);

    // ==================================================================
    // Expected trace and scoreboard state
    // ==================================================================

    ptp_tag_pkg::axis_beat_t exp_beat [256];     // Trace beats in file order.
    ptp_tag_pkg::lane_t      exp_lane [256];     // Source lane of each trace beat.
    int                      exp_total = 0;      // Number of beats loaded.
    int                      rd_idx [`PTP_NUM_LANES];      // Next unconsumed index per lane.
    ptp_tag_pkg::seq_t       frame_cnt [`PTP_NUM_LANES];   // Frames seen per lane.
    int                      others_done [`PTP_NUM_LANES]; // Foreign frames while waiting.
    int                      beats_seen = 0;     // Output handshakes so far.
    int                      err_data = 0;       // Data, keep, last or bit 0 mismatches.
    int                      err_tag = 0;        // Wrong tag values.
    int                      err_order = 0;      // Frames that interleave.
    int                      err_fair = 0;       // Lanes skipped too often.
    int                      err_misc = 0;       // Invented, missing or early beats.
    logic                    seen_in = 1'b0;     // Some input beat was accepted.
    logic                    mid_frame = 1'b0;   // Last output beat had no last flag.
    ptp_tag_pkg::lane_t      prev_lane = '0;     // Lane of the previous output beat.

    initial begin
        for (int k = 0; k < `PTP_NUM_LANES; k++) begin
            rd_idx[k]      = 0;
            frame_cnt[k]   = '0;                 // Tag counts start at 0 after reset.
            others_done[k] = 0;
        end
    end

    task automatic add_beat(input ptp_tag_pkg::lane_t lane, input ptp_tag_pkg::axis_beat_t beat);
        exp_beat[exp_total] = beat;
        exp_lane[exp_total] = lane;
        exp_total++;
    endtask

    function automatic int find_next(input int lane, input int from);
        for (int i = from; i < exp_total; i++) begin
            if (int'(exp_lane[i]) == lane) begin
                return i;                        // Oldest beat of that lane not yet seen.
            end
        end
        return exp_total;
    endfunction

    function automatic bit differs(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        if (exp !== act) begin
            $display("Fail t=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // ==================================================================
    // Per-cycle comparison, sampled on the rising edge
    // ==================================================================

    always @(posedge clk) begin : watch
        ptp_tag_pkg::tag_t  tag;
        ptp_tag_pkg::lane_t lane;
        int                 idx;
        if (!rst) begin
            if (out_valid && !seen_in) begin
                err_misc++;                      // Output must stay empty until a beat enters.
                $display("Error at %0t: out_valid is high before any input beat", $time);
            end
            if (|(in_valid & in_ready)) begin
                seen_in = 1'b1;
            end
            if (out_valid && out_ready) begin
                tag  = out_beat.user[`PTP_TAG_OFFSET +: `PTP_TAG_WIDTH];
                lane = tag[`PTP_TAG_WIDTH-1 -: `PTP_LANE_BITS]; // Lane rides in the tag MSBs.
                if (mid_frame && lane != prev_lane) begin
                    err_order++;
                    $display("Error at %0t: frame of lane %0d cut by lane %0d", $time,
                             prev_lane, lane);
                end
                idx = find_next(lane, rd_idx[lane]);
                if (idx >= exp_total) begin
                    err_misc++;
                    $display("Error at %0t: lane %0d sent a beat not in the trace", $time, lane);
                end else begin
                    err_data += differs("out_beat.data", exp_beat[idx].data, out_beat.data);
                    err_data += differs("out_beat.keep", exp_beat[idx].keep, out_beat.keep);
                    err_data += differs("out_beat.last", exp_beat[idx].last, out_beat.last);
                    err_data += differs("out_beat.user[0]", exp_beat[idx].user[0],
                                        out_beat.user[0]);
                    rd_idx[lane] = idx + 1;      // Consume it, keeping per-lane order.
                end
                // Lane number over the frame count of that lane.
                err_tag += differs("out_beat.user.tag", {lane, frame_cnt[lane]}, tag);
                if (!mid_frame) begin
                    others_done[lane] = 0;       // Own frame started, the wait is over.
                end
                if (out_beat.last) begin
                    frame_cnt[lane]++;           // Wraps at 2**14 like the allocator.
                    for (int k = 0; k < `PTP_NUM_LANES; k++) begin
                        if (k != int'(lane) && in_valid[k]) begin
                            others_done[k]++;
                            if (others_done[k] > `PTP_NUM_LANES - 1) begin
                                err_fair++;
                                $display("Error at %0t: lane %0d passed over by %0d frames",
                                         $time, k, others_done[k]);
                            end
                        end
                    end
                end
                mid_frame = !out_beat.last;
                prev_lane = lane;
                beats_seen++;
            end
            for (int k = 0; k < `PTP_NUM_LANES; k++) begin
                if (!in_valid[k]) begin
                    others_done[k] = 0;          // Nothing pending, nothing to be fair to.
                end
            end
        end
    end

    // ==================================================================
    // Closing summary
    // ==================================================================

    task automatic report_counts();
        for (int k = 0; k < `PTP_NUM_LANES; k++) begin
            if (find_next(k, rd_idx[k]) < exp_total) begin
                err_misc++;
                $display("Error: lane %0d has trace beats that never reached the output", k);
            end
        end
        if (beats_seen != exp_total) begin
            err_misc++;
            $display("Error: %0d beats left the DUT but the trace holds %0d", beats_seen,
                     exp_total);
        end
        $display("Errors: data=%0d tag=%0d order=%0d fairness=%0d other=%0d assert=%0d total=%0d",
                 err_data, err_tag, err_order, err_fair, err_misc, assert_errors,
                 total_errors());
    endtask

    function automatic int total_errors();
        return err_data + err_tag + err_order + err_fair + err_misc + assert_errors;
    endfunction

endmodule

// File: tb_ptp_tag.sv
// Reads ptp_tag_trace.txt from the run directory; '#' lines are comments, 256 beats at most.
`include "ptp_tag_macros.svh"

module tb_ptp_tag;

    logic                      clk;
    logic                      rst;
    ptp_tag_pkg::axis_beat_t   in_beat [`PTP_NUM_LANES];
    logic [`PTP_NUM_LANES-1:0] in_valid;
    logic [`PTP_NUM_LANES-1:0] in_ready;
    ptp_tag_pkg::axis_beat_t   out_beat;
    logic                      out_valid;
    logic                      out_ready;

    ptp_tag_pkg::axis_beat_t trace_beat [256];   // Beats in file order.
    ptp_tag_pkg::lane_t      trace_lane [256];   // Lane of each beat.
    int                      trace_total = 0;
    int                      drv_idx [`PTP_NUM_LANES]; // Beat now offered on each lane.
    int                      frames_out = 0;     // Completed output frames.
    logic [7:0]              lfsr_q = 8'd73;     // Seed of the ready pattern.
    logic                    loaded = 1'b0;      // Trace is in memory.

    tb_clk_gen clk_gen (.clk(clk), .rst(rst));

    ptp_tag_subsys uut (
        .clk(clk), .rst(rst), .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
    );

    tb_ptp_checker chk (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
        .assert_errors(uut.sva.fail_count)
    );

    bind ptp_tag_subsys tb_ptp_tag_sva sva (
        .clk(clk), .rst(rst), .in_ready(in_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
    );

    // 8-bit maximal Fibonacci LFSR, taps 8, 6, 5 and 4.
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int next_of(input int lane, input int from);
        for (int i = from; i < trace_total; i++) begin
            if (int'(trace_lane[i]) == lane) begin
                return i;
            end
        end
        return trace_total;                      // Lane has nothing left to send.
    endfunction

    task automatic load_trace(output bit ok);
        int          fd;
        int          lane;
        int          last;
        int          u0;
        logic [63:0] data;
        logic [7:0]  keep;
        string       line;
        ptp_tag_pkg::axis_beat_t beat;
        fd = $fopen("ptp_tag_trace.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.getc(0) != "#" &&
                    $sscanf(line, "%d %h %h %d %d", lane, data, keep, last, u0) == 5) begin
                    beat = '{data: data, keep: keep, last: last[0],
                             user: {{`PTP_TAG_WIDTH{1'b1}}, u0[0]}}; // Tag bits get overwritten.
                    trace_beat[trace_total] = beat;
                    trace_lane[trace_total] = ptp_tag_pkg::lane_t'(lane);
                    chk.add_beat(ptp_tag_pkg::lane_t'(lane), beat);
                    trace_total++;
                end
            end
            $fclose(fd);
        end
        ok = (trace_total > 0);
    endtask

    // ==================================================================
    // Stimulus, driven on the rising edge
    // ==================================================================

    always @(posedge clk) begin
        if (rst) begin
            in_valid  <= '0;
            out_ready <= 1'b0;
        end else begin
            for (int k = 0; k < `PTP_NUM_LANES; k++) begin
                if (in_valid[k] && in_ready[k]) begin
                    drv_idx[k] = next_of(k, drv_idx[k] + 1); // Beat taken, offer the next.
                end
                in_valid[k] <= (drv_idx[k] < trace_total);
                if (drv_idx[k] < trace_total) begin
                    in_beat[k] <= trace_beat[drv_idx[k]];
                end
            end
            if (out_valid && out_ready && out_beat.last) begin
                frames_out++;
            end
            lfsr_q = lfsr_step(lfsr_q);          // One step per ready bit.
            out_ready <= (frames_out < 4) ? 1'b1 : lfsr_q[0]; // Free flow for the first frames.
        end
    end

    initial begin : main
        bit setup_ok;
        in_valid  = '0;
        out_ready = 1'b0;
        for (int k = 0; k < `PTP_NUM_LANES; k++) begin
            in_beat[k] = '0;
        end
        load_trace(setup_ok);
        for (int k = 0; k < `PTP_NUM_LANES; k++) begin
            drv_idx[k] = next_of(k, 0);
        end
        loaded = 1'b1;
        if (setup_ok) begin
            while (chk.beats_seen < trace_total) @(posedge clk);
            repeat (20) @(posedge clk);          // Room for any invented extra beat.
        end else begin
            $display("Error: trace file ptp_tag_trace.txt is missing or holds no beats");
        end
        chk.report_counts();
        if (setup_ok && chk.total_errors() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        while (!loaded) @(posedge clk);
        limit = trace_total * 8 + 200;           // Cycles allowed for the whole trace.
        repeat (limit) @(posedge clk);
        $display("Timeout: not all %0d trace beats left the DUT in %0d cycles", trace_total,
                 limit);
        chk.report_counts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: tb_ptp_tag_sva.sv
// Bound into ptp_tag_subsys; every property is disabled while rst is high except the reset one.
`include "ptp_tag_macros.svh"

module tb_ptp_tag_sva (
    input logic                      clk,
    input logic                      rst,
    input logic [`PTP_NUM_LANES-1:0] in_ready,
    input ptp_tag_pkg::axis_beat_t   out_beat,
    input logic                      out_valid,
    input logic                      out_ready
);

    int fail_count = 0;                          // Assertion failures so far.

    // A stalled output beat must neither vanish nor change.
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else begin
            $error("out_beat changed or dropped while stalled");
            fail_count++;
        end

    // The output register is empty right after reset.
    assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset");
            fail_count++;
        end

    // Only the granted lane may see ready.
    assert property (@(posedge clk) disable iff (rst) $onehot0(in_ready))
        else begin
            $error("in_ready has more than one lane high");
            fail_count++;
        end

endmodule
